// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_gaussian_pyramid
FILELIST   := gaussian_pyramid.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh verif/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== blur/blur_engine.sv ====
`default_nettype none

`include "pyramid_params.svh"

module blur_engine (
    input  wire                   clk_in,
    input  wire                   rst_in,
    input  wire                   start,
    input  wire pyramid_pkg::octave_t octave,
    output pixel_pkg::addr_t      rd_addr,
    output logic                  rd_en,
    input  wire pixel_pkg::pixel_t rd_pixel,
    output pixel_pkg::pix_wr_t    wr,
    output logic                  wr_en,
    output logic                  done
);

    logic                 busy;
    logic [3:0]           tap;           // 0..8 reads, 9 last data, 10 write
    logic [1:0]           tap_r, tap_c;  // window row and column of the next read
    logic                 rd_valid;
    logic [1:0]           wt, wt_q;      // weight of 1 2 or 4 as a shift
    logic                 fin_q;
    pyramid_pkg::octave_t oct_q;
    pixel_pkg::coord_t    x, y, nx, ny;
    pixel_pkg::coord_t    last_x, last_y;
    logic [2:0]           row_shift;
    logic [`PYR_BIT_DEPTH+3:0] acc, rounded;

    assign row_shift = 3'($clog2(`PYR_TOP_WIDTH)) - 3'(oct_q);
    assign last_x    = pixel_pkg::coord_t'((`PYR_TOP_WIDTH >> oct_q) - 1);
    assign last_y    = pixel_pkg::coord_t'((`PYR_TOP_HEIGHT >> oct_q) - 1);

    // clamp the neighbour at the image border
    always_comb begin
        nx = x;
        ny = y;
        if (tap_c == 2'd0 && x != '0)
            nx = x - 1'b1;
        if (tap_c == 2'd2 && x != last_x)
            nx = x + 1'b1;
        if (tap_r == 2'd0 && y != '0)
            ny = y - 1'b1;
        if (tap_r == 2'd2 && y != last_y)
            ny = y + 1'b1;
    end

    assign rd_en   = busy && (tap < 4'd9);
    assign rd_addr = (pixel_pkg::addr_t'(ny) << row_shift) | pixel_pkg::addr_t'(nx);
    assign wt      = 2'(tap_r == 2'd1) + 2'(tap_c == 2'd1);
    assign rounded = acc + (`PYR_BIT_DEPTH+4)'(8);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy     <= 1'b0;
            tap      <= '0;
            tap_r    <= '0;
            tap_c    <= '0;
            rd_valid <= 1'b0;
            wr_en    <= 1'b0;
            fin_q    <= 1'b0;
            done     <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            wr_en    <= 1'b0;
            fin_q    <= 1'b0;
            done     <= fin_q;  // one cycle after the last write
            if (start && !busy) begin
                busy  <= 1'b1;
                tap   <= '0;
                tap_r <= '0;
                tap_c <= '0;
                x     <= '0;
                y     <= '0;
                oct_q <= octave;
            end else if (busy) begin
                if (tap == 4'd10) begin
                    tap   <= '0;
                    wr_en <= 1'b1;
                    if (x == last_x) begin
                        x <= '0;
                        if (y == last_y) begin
                            busy  <= 1'b0;
                            fin_q <= 1'b1;
                        end else begin
                            y <= y + 1'b1;
                        end
                    end else begin
                        x <= x + 1'b1;
                    end
                end else begin
                    tap <= tap + 1'b1;
                    if (rd_en) begin
                        tap_c <= (tap_c == 2'd2) ? 2'd0 : tap_c + 1'b1;
                        if (tap_c == 2'd2)
                            tap_r <= (tap_r == 2'd2) ? 2'd0 : tap_r + 1'b1;
                    end
                end
            end
        end
    end

    // accumulator and write payload
    always_ff @(posedge clk_in) begin
        wt_q <= wt;
        if ((start && !busy) || (busy && tap == 4'd10))
            acc <= '0;
        else if (rd_valid)
            acc <= acc + ((`PYR_BIT_DEPTH+4)'(rd_pixel) << wt_q);
        if (busy && tap == 4'd10) begin
            wr.addr  <= (pixel_pkg::addr_t'(y) << row_shift) | pixel_pkg::addr_t'(x);
            wr.pixel <= rounded[`PYR_BIT_DEPTH+3:4];  // rounded division by 16
        end
    end

endmodule

`default_nettype wire

// ==== common/pixel_pkg.sv ====
`default_nettype none

`include "pyramid_params.svh"

package pixel_pkg;

    typedef logic [`PYR_BIT_DEPTH-1:0] pixel_t;

    // row-major address inside the image of the current octave
    typedef logic [`PYR_ADDR_WIDTH-1:0] addr_t;

    typedef logic [$clog2(`PYR_TOP_WIDTH)-1:0] coord_t;  // x or y

    // one pixel write, used by every engine and buffer
    typedef struct packed {
        addr_t  addr;
        pixel_t pixel;
    } pix_wr_t;

endpackage

`default_nettype wire

// ==== common/pyramid_params.svh ====
`ifndef PYRAMID_PARAMS_SVH
`define PYRAMID_PARAMS_SVH

// greyscale pixel depth
`define PYR_BIT_DEPTH 8

// octave 0 image size, both powers of two
`define PYR_TOP_WIDTH 16
`define PYR_TOP_HEIGHT 16

// pyramid shape
`define PYR_OCTAVES 3
`define PYR_LEVELS 3

// log2 of the octave 0 pixel count
`define PYR_ADDR_WIDTH 8

`endif

// ==== common/pyramid_pkg.sv ====
`default_nettype none

`include "pyramid_params.svh"

package pyramid_pkg;

    typedef logic [$clog2(`PYR_OCTAVES)-1:0] octave_t;
    typedef logic [$clog2(`PYR_LEVELS)-1:0] level_t;

    typedef struct packed {
        octave_t octave;
        level_t  level;
    } level_tag_t;

    // where a pass reads its image from
    typedef enum logic [1:0] {
        src_ext   = 2'd0,
        src_buf_a = 2'd1,
        src_buf_b = 2'd2
    } buf_sel_t;

    typedef struct packed {
        logic     decimate;  // 0 blur, 1 decimate
        buf_sel_t src;
        logic     dst_b;     // 0 writes buffer a, 1 writes buffer b
        octave_t  octave;
        level_t   level;
        logic     emit;      // level goes out on the output stream
    } pass_cmd_t;

    typedef enum logic [1:0] {
        idle,
        issue,
        wait_pass,
        finish
    } pyr_state_t;

endpackage

`default_nettype wire

// ==== gaussian_pyramid.f ====
+incdir+common
+incdir+verif
common/pixel_pkg.sv
common/pyramid_pkg.sv
source/frame_buffer.sv
source/half_sampler.sv
blur/blur_engine.sv
source/pyramid_ctrl.sv
source/gaussian_pyramid.sv
verif/tb_gaussian_pyramid.sv

// ==== source/frame_buffer.sv ====
`default_nettype none

`include "pyramid_params.svh"

module frame_buffer (
    input  wire                     clk_in,
    input  wire pixel_pkg::pix_wr_t wr,
    input  wire                     wr_en,
    input  wire pixel_pkg::addr_t   rd_addr,
    input  wire                     rd_en,
    output pixel_pkg::pixel_t       rd_pixel
);

    // sized for the octave 0 image, smaller octaves use the low part
    pixel_pkg::pixel_t mem [2**`PYR_ADDR_WIDTH];

    always_ff @(posedge clk_in) begin
        if (wr_en)
            mem[wr.addr] <= wr.pixel;
        if (rd_en)
            rd_pixel <= mem[rd_addr];  // read-first on a collision
    end

endmodule

`default_nettype wire

// ==== source/gaussian_pyramid.sv ====
`default_nettype none

module gaussian_pyramid (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire                      start_in,
    output pixel_pkg::addr_t         ext_read_addr,
    output logic                     ext_read_valid,
    input  wire pixel_pkg::pixel_t   ext_pixel_in,
    output pixel_pkg::pix_wr_t       level_wr,
    output logic                     level_wr_valid,
    output pyramid_pkg::level_tag_t  level_tag,
    output logic                     pyramid_done
);

    pyramid_pkg::pass_cmd_t pass_cmd;
    logic                   pass_start, pass_done;
    logic                   blur_done, hs_done;
    pixel_pkg::addr_t       blur_rd_addr, hs_rd_addr, rd_addr;
    logic                   blur_rd_en, hs_rd_en, rd_en;
    pixel_pkg::pixel_t      rd_pixel, buf_a_pixel, buf_b_pixel;
    pixel_pkg::pix_wr_t     blur_wr, hs_wr, eng_wr;
    logic                   blur_wr_en, hs_wr_en, eng_wr_en;

    pyramid_ctrl u_ctrl (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .start_in     (start_in),
        .pass_done    (pass_done),
        .pass_cmd     (pass_cmd),
        .pass_start   (pass_start),
        .pyramid_done (pyramid_done)
    );

    blur_engine u_blur (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .start    (pass_start && !pass_cmd.decimate),
        .octave   (pass_cmd.octave),
        .rd_addr  (blur_rd_addr),
        .rd_en    (blur_rd_en),
        .rd_pixel (rd_pixel),
        .wr       (blur_wr),
        .wr_en    (blur_wr_en),
        .done     (blur_done)
    );

    half_sampler u_half (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .start    (pass_start && pass_cmd.decimate),
        .octave   (pass_cmd.octave),
        .rd_addr  (hs_rd_addr),
        .rd_en    (hs_rd_en),
        .rd_pixel (rd_pixel),
        .wr       (hs_wr),
        .wr_en    (hs_wr_en),
        .done     (hs_done)
    );

    assign pass_done = blur_done | hs_done;

    // only the engine named by the command is active during a pass
    assign rd_addr   = pass_cmd.decimate ? hs_rd_addr : blur_rd_addr;
    assign rd_en     = pass_cmd.decimate ? hs_rd_en : blur_rd_en;
    assign eng_wr    = pass_cmd.decimate ? hs_wr : blur_wr;
    assign eng_wr_en = pass_cmd.decimate ? hs_wr_en : blur_wr_en;

    assign ext_read_addr  = rd_addr;
    assign ext_read_valid = rd_en && (pass_cmd.src == pyramid_pkg::src_ext);

    // source is fixed for the pass, so the one-cycle read delay needs no tracking
    always_comb begin
        case (pass_cmd.src)
            pyramid_pkg::src_buf_a: rd_pixel = buf_a_pixel;
            pyramid_pkg::src_buf_b: rd_pixel = buf_b_pixel;
            default:                rd_pixel = ext_pixel_in;
        endcase
    end

    frame_buffer u_buf_a (
        .clk_in   (clk_in),
        .wr       (eng_wr),
        .wr_en    (eng_wr_en && !pass_cmd.dst_b),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en && (pass_cmd.src == pyramid_pkg::src_buf_a)),
        .rd_pixel (buf_a_pixel)
    );

    frame_buffer u_buf_b (
        .clk_in   (clk_in),
        .wr       (eng_wr),
        .wr_en    (eng_wr_en && pass_cmd.dst_b),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en && (pass_cmd.src == pyramid_pkg::src_buf_b)),
        .rd_pixel (buf_b_pixel)
    );

    // blurred levels leave on one tagged stream
    assign level_wr         = blur_wr;
    assign level_wr_valid   = blur_wr_en && pass_cmd.emit;
    assign level_tag.octave = pass_cmd.octave;
    assign level_tag.level  = pass_cmd.level;

endmodule

`default_nettype wire

// ==== source/half_sampler.sv ====
`default_nettype none

`include "pyramid_params.svh"

module half_sampler (
    input  wire                   clk_in,
    input  wire                   rst_in,
    input  wire                   start,
    input  wire pyramid_pkg::octave_t octave,  // destination octave
    output pixel_pkg::addr_t      rd_addr,
    output logic                  rd_en,
    input  wire pixel_pkg::pixel_t rd_pixel,
    output pixel_pkg::pix_wr_t    wr,
    output logic                  wr_en,
    output logic                  done
);

    logic                 busy;
    logic [1:0]           phase;  // read, capture, advance
    pyramid_pkg::octave_t oct_q;
    pixel_pkg::coord_t    x, y, last_x, last_y;
    logic [2:0]           dst_shift, src_shift;

    assign dst_shift = 3'($clog2(`PYR_TOP_WIDTH)) - 3'(oct_q);
    assign src_shift = dst_shift + 3'd1;  // source rows are twice as wide
    assign last_x    = pixel_pkg::coord_t'((`PYR_TOP_WIDTH >> oct_q) - 1);
    assign last_y    = pixel_pkg::coord_t'((`PYR_TOP_HEIGHT >> oct_q) - 1);

    assign rd_en   = busy && (phase == 2'd0);
    assign rd_addr = ((pixel_pkg::addr_t'(y) << 1) << src_shift) | (pixel_pkg::addr_t'(x) << 1);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy  <= 1'b0;
            phase <= '0;
            wr_en <= 1'b0;
            done  <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            done  <= 1'b0;
            if (start && !busy) begin
                busy  <= 1'b1;
                phase <= '0;
                x     <= '0;
                y     <= '0;
                oct_q <= octave;
            end else if (busy) begin
                phase <= (phase == 2'd2) ? 2'd0 : phase + 1'b1;
                if (phase == 2'd1)
                    wr_en <= 1'b1;  // source pixel is on rd_pixel now
                if (phase == 2'd2) begin
                    if (x == last_x) begin
                        x <= '0;
                        if (y == last_y) begin
                            busy <= 1'b0;
                            done <= 1'b1;
                        end else begin
                            y <= y + 1'b1;
                        end
                    end else begin
                        x <= x + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (busy && phase == 2'd1) begin
            wr.addr  <= (pixel_pkg::addr_t'(y) << dst_shift) | pixel_pkg::addr_t'(x);
            wr.pixel <= rd_pixel;
        end
    end

endmodule

`default_nettype wire

// ==== source/pyramid_ctrl.sv ====
`default_nettype none

`include "pyramid_params.svh"

module pyramid_ctrl (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    start_in,
    input  wire                    pass_done,
    output pyramid_pkg::pass_cmd_t pass_cmd,
    output logic                   pass_start,
    output logic                   pyramid_done
);

    pyramid_pkg::pyr_state_t state;
    pyramid_pkg::octave_t    octave;
    pyramid_pkg::level_t     level;
    logic                    dec_pending;  // decimation still owed for this octave

    // command follows the counters, which hold still for the whole pass
    always_comb begin
        pass_cmd        = '0;
        pass_cmd.octave = octave;
        if (dec_pending) begin
            pass_cmd.decimate = 1'b1;
            pass_cmd.src      = pyramid_pkg::src_buf_a;  // third level of previous octave
            pass_cmd.dst_b    = 1'b1;
        end else begin
            pass_cmd.level = level;
            pass_cmd.emit  = 1'b1;
            pass_cmd.dst_b = (level == 2'd1);
            if (level == 2'd1)
                pass_cmd.src = pyramid_pkg::src_buf_a;
            else if (level == 2'd0 && octave == 2'd0)
                pass_cmd.src = pyramid_pkg::src_ext;
            else
                pass_cmd.src = pyramid_pkg::src_buf_b;
        end
    end

    assign pass_start   = (state == pyramid_pkg::issue);
    assign pyramid_done = (state == pyramid_pkg::finish);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state       <= pyramid_pkg::idle;
            octave      <= '0;
            level       <= '0;
            dec_pending <= 1'b0;
        end else begin
            case (state)
                pyramid_pkg::idle: begin
                    if (start_in) begin
                        octave      <= '0;
                        level       <= '0;
                        dec_pending <= 1'b0;
                        state       <= pyramid_pkg::issue;
                    end
                end
                pyramid_pkg::issue: state <= pyramid_pkg::wait_pass;
                pyramid_pkg::wait_pass: begin
                    if (pass_done) begin
                        state <= pyramid_pkg::issue;
                        if (dec_pending) begin
                            dec_pending <= 1'b0;  // blur of level 0 comes next
                        end else if (level == pyramid_pkg::level_t'(`PYR_LEVELS - 1)) begin
                            if (octave == pyramid_pkg::octave_t'(`PYR_OCTAVES - 1)) begin
                                state <= pyramid_pkg::finish;
                            end else begin
                                octave      <= octave + 1'b1;
                                level       <= '0;
                                dec_pending <= 1'b1;
                            end
                        end else begin
                            level <= level + 1'b1;
                        end
                    end
                end
                default: state <= pyramid_pkg::idle;  // finish lasts one cycle
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verif/pyramid_model.svh ====
`ifndef PYRAMID_MODEL_SVH
`define PYRAMID_MODEL_SVH

// working image of the model, row-major at the size of the current octave
int model_img [`PYR_TOP_WIDTH*`PYR_TOP_HEIGHT];
int model_tmp [`PYR_TOP_WIDTH*`PYR_TOP_HEIGHT];

function automatic int clamp_coord(input int v, input int last);
    if (v < 0)
        return 0;
    if (v > last)
        return last;
    return v;
endfunction

// one 1-2-1 by 1-2-1 pass over model_img, kept as expected level idx
task automatic blur_model(input int w, input int h, input int idx);
    int sum;
    int wgt;
    int pos;
    for (int y = 0; y < h; y++) begin
        for (int x = 0; x < w; x++) begin
            sum = 0;
            for (int dy = -1; dy <= 1; dy++) begin
                for (int dx = -1; dx <= 1; dx++) begin
                    wgt = (dy == 0 ? 2 : 1) * (dx == 0 ? 2 : 1);
                    pos = clamp_coord(y + dy, h - 1) * w + clamp_coord(x + dx, w - 1);
                    sum += wgt * model_img[pos];
                end
            end
            model_tmp[y * w + x] = (sum + 8) >> 4;  // divide by 16, rounded
        end
    end
    for (int i = 0; i < w * h; i++) begin
        model_img[i]      = model_tmp[i];
        exp_level[idx][i] = pixel_pkg::pixel_t'(model_tmp[i]);
    end
endtask

// keep even rows and even columns of a w by h image
task automatic decimate_model(input int w, input int h);
    for (int y = 0; y < h / 2; y++) begin
        for (int x = 0; x < w / 2; x++) begin
            model_tmp[y * (w / 2) + x] = model_img[2 * y * w + 2 * x];
        end
    end
    for (int i = 0; i < (w / 2) * (h / 2); i++) begin
        model_img[i] = model_tmp[i];
    end
endtask

// all nine levels from the image now held in ext_mem
task automatic build_model();
    int w;
    int h;
    w = `PYR_TOP_WIDTH;
    h = `PYR_TOP_HEIGHT;
    for (int i = 0; i < w * h; i++) begin
        model_img[i] = int'(ext_mem[i]);
    end
    for (int o = 0; o < `PYR_OCTAVES; o++) begin
        if (o > 0) begin
            decimate_model(w, h);  // from the third level of the previous octave
            w = w / 2;
            h = h / 2;
        end
        for (int l = 0; l < `PYR_LEVELS; l++) begin
            blur_model(w, h, o * `PYR_LEVELS + l);
        end
    end
endtask

`endif

// ==== verif/tb_gaussian_pyramid.sv ====
`default_nettype none

`include "pyramid_params.svh"

module tb_gaussian_pyramid;

    localparam int NUM_LEVELS   = `PYR_OCTAVES * `PYR_LEVELS;
    localparam int TOP_PIXELS   = `PYR_TOP_WIDTH * `PYR_TOP_HEIGHT;
    localparam int RUN_TIMEOUT  = 20000;  // cycles allowed for one whole pyramid
    localparam int QUIET_CYCLES = 300;

    logic                    clk_in;
    logic                    rst_in;
    logic                    start_in;
    pixel_pkg::addr_t        ext_read_addr;
    logic                    ext_read_valid;
    pixel_pkg::pixel_t       ext_pixel_in;
    pixel_pkg::pix_wr_t      level_wr;
    logic                    level_wr_valid;
    pyramid_pkg::level_tag_t level_tag;
    logic                    pyramid_done;

    pixel_pkg::pixel_t ext_mem [TOP_PIXELS];
    pixel_pkg::pixel_t exp_level [NUM_LEVELS][TOP_PIXELS];
    pixel_pkg::pixel_t ext_word;
    pixel_pkg::pixel_t const_val;
    bit                seen [NUM_LEVELS][TOP_PIXELS];
    int                write_count [NUM_LEVELS];
    int                cur_level;
    int                done_count;
    int                value_errors = 0;
    int                other_errors = 0;
    bit                run_active;
    bit                const_run;

    `include "pyramid_model.svh"

    gaussian_pyramid u_dut (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .start_in       (start_in),
        .ext_read_addr  (ext_read_addr),
        .ext_read_valid (ext_read_valid),
        .ext_pixel_in   (ext_pixel_in),
        .level_wr       (level_wr),
        .level_wr_valid (level_wr_valid),
        .level_tag      (level_tag),
        .pyramid_done   (pyramid_done)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic value_error(input string msg);
        value_errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic other_error(input string msg);
        other_errors++;
        $display("%s", msg);
    endtask

    function automatic int level_pixels(input int idx);
        int oct;
        oct = idx / `PYR_LEVELS;
        return (`PYR_TOP_WIDTH >> oct) * (`PYR_TOP_HEIGHT >> oct);
    endfunction

    // external image memory, one cycle read latency
    always @(posedge clk_in) begin
        if (ext_read_valid) begin
            ext_word = ext_mem[ext_read_addr];
            #1 ext_pixel_in = ext_word;
        end
    end

    task automatic score_write();
        int idx;
        int addr;
        idx  = int'(level_tag.octave) * `PYR_LEVELS + int'(level_tag.level);
        addr = int'(level_wr.addr);
        assert (done_count == 0)
        else other_error("an output write came after pyramid_done");
        if (idx >= NUM_LEVELS || int'(level_tag.level) >= `PYR_LEVELS) begin
            value_error($sformatf("invalid level tag %0d,%0d", level_tag.octave,
                                  level_tag.level));
        end else begin
            if (idx != cur_level) begin
                assert (idx == cur_level + 1)
                else value_error($sformatf("level tag %0d,%0d out of order", level_tag.octave,
                                           level_tag.level));
                if (cur_level >= 0) begin
                    assert (write_count[cur_level] == level_pixels(cur_level))
                    else other_error($sformatf("level %0d ended after %0d of %0d pixels",
                                     cur_level, write_count[cur_level],
                                     level_pixels(cur_level)));
                end
                cur_level = idx;
            end
            assert (addr < level_pixels(idx))
            else value_error($sformatf("level %0d address %0d outside the image", idx, addr));
            assert (!seen[idx][addr])
            else value_error($sformatf("level %0d address %0d written twice", idx, addr));
            seen[idx][addr] = 1'b1;
            write_count[idx]++;
            assert (level_wr.pixel == exp_level[idx][addr])
            else value_error($sformatf("level %0d addr %0d pixel %0d expected %0d", idx, addr,
                                       level_wr.pixel, exp_level[idx][addr]));
            if (const_run) begin
                assert (level_wr.pixel == const_val)
                else value_error($sformatf("level %0d addr %0d pixel %0d not constant %0d",
                                           idx, addr, level_wr.pixel, const_val));
            end
        end
    endtask

    task automatic note_done();
        done_count++;
        assert (done_count == 1)
        else other_error("pyramid_done pulsed more than once in one run");
        assert (cur_level == NUM_LEVELS - 1 &&
                write_count[NUM_LEVELS-1] == level_pixels(NUM_LEVELS - 1))
        else other_error("pyramid_done came before the last level was complete");
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk_in) begin
        if (!run_active) begin
            assert (!ext_read_valid && !level_wr_valid && !pyramid_done)
            else value_error("output strobe high while no run is active");
        end
        if (!rst_in && level_wr_valid)
            score_write();
        if (!rst_in && pyramid_done)
            note_done();
    end

    assert property (@(posedge clk_in) disable iff (rst_in) pyramid_done |=> !pyramid_done)
        else other_error("pyramid_done stayed high for more than one cycle");

    assert property (@(posedge clk_in) disable iff (rst_in)
                     pyramid_done |-> !level_wr_valid && !ext_read_valid)
        else other_error("pyramid_done overlapped an output strobe");

    task automatic reset_scoreboard();
        for (int i = 0; i < NUM_LEVELS; i++) begin
            write_count[i] = 0;
            for (int a = 0; a < TOP_PIXELS; a++)
                seen[i][a] = 1'b0;
        end
        cur_level  = -1;
        done_count = 0;
    endtask

    task automatic audit_counts();
        for (int i = 0; i < NUM_LEVELS; i++) begin
            assert (write_count[i] == level_pixels(i))
            else other_error($sformatf("level %0d,%0d wrote %0d of %0d pixels",
                             i / `PYR_LEVELS, i % `PYR_LEVELS, write_count[i],
                             level_pixels(i)));
        end
        assert (done_count == 1)
        else other_error($sformatf("pyramid_done pulsed %0d times in one run", done_count));
    endtask

    task automatic run_pyramid(output bit finished);
        int n;
        reset_scoreboard();
        build_model();
        @(posedge clk_in);
        #1;
        run_active = 1'b1;
        start_in   = 1'b1;
        @(posedge clk_in);
        #1;
        start_in = 1'b0;
        repeat (100) @(posedge clk_in);
        #1;
        start_in = 1'b1;  // lands in the first blur, must be ignored
        @(posedge clk_in);
        #1;
        start_in = 1'b0;
        n = 0;
        while (done_count == 0 && n < RUN_TIMEOUT) begin
            @(posedge clk_in);
            n++;
        end
        finished = (done_count != 0);
        if (!finished) begin
            other_error($sformatf("timeout after %0d cycles waiting for pyramid_done",
                                  RUN_TIMEOUT));
        end else begin
            #1 run_active = 1'b0;
            repeat (QUIET_CYCLES) @(posedge clk_in);  // no second run may follow
            audit_counts();
        end
    endtask

    initial begin
        bit finished;
        rst_in       = 1'b1;
        start_in     = 1'b0;
        ext_pixel_in = '0;
        run_active   = 1'b0;
        const_run    = 1'b0;
        const_val    = '0;
        cur_level    = -1;
        done_count   = 0;
        void'($urandom(32'hf3ec5280));
        for (int i = 0; i < TOP_PIXELS; i++)
            ext_mem[i] = pixel_pkg::pixel_t'($urandom);
        repeat (5) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        repeat (4) @(posedge clk_in);  // idle, strobes must stay low
        run_pyramid(finished);
        if (finished) begin
            const_val = pixel_pkg::pixel_t'($urandom);
            const_run = 1'b1;
            for (int i = 0; i < TOP_PIXELS; i++)
                ext_mem[i] = const_val;
            run_pyramid(finished);
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
